// File: files.f
hdl/tlu_pkg.sv
hdl/stage_if.sv
hdl/tlu_trigger_handshake.sv
hdl/tlu_serial_reader.sv
hdl/trigger_word_out.sv
hdl/tlu_controller.sv
test/tb_tlu_controller.sv

// File: hdl/stage_if.sv
// four-phase req/ack link between pipeline stages, payload type set per instance
`timescale 1ns/1ns

interface stage_if #(
    parameter type payload_t = logic
) ();

    // source holds payload stable while req is high
    logic     req;
    logic     ack;
    payload_t payload;

    modport source
    (
        output req,
        output payload,
        input  ack
    );

    modport sink
    (
        input  req,
        input  payload,
        output ack
    );

endinterface

// File: hdl/tlu_controller.sv
// TLU controller top level: trigger handshake, serial readout and word output in a pipeline
`timescale 1ns/1ns

module tlu_controller
(
    input  logic                              CLK,
    input  logic                              RESET,

    // TLU side
    input  logic                              tlu_trigger,
    input  logic                              tlu_data,
    output logic                              tlu_busy,
    output logic                              tlu_clk,

    // configuration
    input  logic                              data_mode,
    input  logic [tlu_pkg::TIMEOUT_WIDTH-1:0] timeout,
    input  logic [tlu_pkg::CYCLES_WIDTH-1:0]  clock_cycles,
    output logic                              timeout_error,

    // downstream writer
    output logic                              word_req,
    output tlu_pkg::trigger_word_t            word_data,
    input  logic                              word_ack
);

    // accepted trigger with its timestamp
    stage_if #(.payload_t(tlu_pkg::trigger_event_t)) ev_if ();

    // finished output word
    stage_if #(.payload_t(tlu_pkg::trigger_word_t)) wd_if ();

    tlu_trigger_handshake u_handshake
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .tlu_trigger   (tlu_trigger),
        .data_mode     (data_mode),
        .timeout       (timeout),
        .tlu_busy      (tlu_busy),
        .timeout_error (timeout_error),
        .ev            (ev_if.source)
    );

    tlu_serial_reader u_reader
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .clock_cycles (clock_cycles),
        .tlu_data     (tlu_data),
        .tlu_clk      (tlu_clk),
        .ev           (ev_if.sink),
        .wd           (wd_if.source)
    );

    trigger_word_out u_word_out
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wd        (wd_if.sink),
        .word_req  (word_req),
        .word_data (word_data),
        .word_ack  (word_ack)
    );

endmodule

// File: hdl/tlu_pkg.sv
// shared widths, TLU clock divisor and stage payload types, referenced by scoped name
package tlu_pkg;

    // system clock cycles per TLU clock period
    localparam int TLU_CLOCK_DIVISOR = 8;

    // counter width for one TLU clock period
    localparam int TLU_DIV_WIDTH = $clog2(TLU_CLOCK_DIVISOR);

    // free-running timestamp, one bit below the word flag
    localparam int TIMESTAMP_WIDTH = 31;

    localparam int WORD_WIDTH = 32;

    // clock_cycles of 0 selects this many TLU clocks
    localparam int MAX_CLOCK_CYCLES = 32;

    localparam int CYCLES_WIDTH = $clog2(MAX_CLOCK_CYCLES);

    // trigger low timeout setting
    localparam int TIMEOUT_WIDTH = 8;

    // event handed from the handshake stage to the reader
    typedef struct packed {
        logic [TIMESTAMP_WIDTH-1:0] timestamp;
        // set means clock the trigger number out of the TLU
        logic                       read_number;
    } trigger_event_t;

    // output word, bit 31 always set
    typedef logic [WORD_WIDTH-1:0] trigger_word_t;

endpackage

// File: hdl/tlu_serial_reader.sv
// second pipeline stage: drives the TLU clock, samples the trigger number, builds the word
`timescale 1ns/1ns

module tlu_serial_reader
(
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic [tlu_pkg::CYCLES_WIDTH-1:0] clock_cycles,
    input  logic                            tlu_data,
    output logic                            tlu_clk,
    stage_if.sink                           ev,
    stage_if.source                         wd
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_SHIFT,
        R_OFFER,
        R_DRAIN
    } state_t;

    state_t                               state;
    logic [tlu_pkg::TLU_DIV_WIDTH-1:0]    div_cnt;
    logic [tlu_pkg::CYCLES_WIDTH-1:0]     per_cnt;
    logic [tlu_pkg::CYCLES_WIDTH-1:0]     cycles_q;
    logic [tlu_pkg::MAX_CLOCK_CYCLES-1:0] shift_sr;
    logic [tlu_pkg::MAX_CLOCK_CYCLES-1:0] aligned;
    tlu_pkg::trigger_word_t               word_q;
    logic                                 tlu_clk_q;
    logic                                 ev_ack_q;
    logic                                 wd_req_q;
    logic                                 start;
    logic                                 sample;
    logic                                 period_end;
    logic                                 last_period;
    logic                                 done;
    int                                   n_periods;

    // new event only once the previous one is fully closed
    assign start = (state == R_IDLE) && ev.req && !ev_ack_q;

    assign n_periods   = (cycles_q == '0) ? tlu_pkg::MAX_CLOCK_CYCLES : int'(cycles_q);
    assign period_end  = int'(div_cnt) == tlu_pkg::TLU_CLOCK_DIVISOR - 1;
    assign last_period = int'(per_cnt) == n_periods - 1;
    // sample on the edge where tlu_clk goes low
    assign sample      = (state == R_SHIFT) &&
                         (int'(div_cnt) == tlu_pkg::TLU_CLOCK_DIVISOR / 2 - 1);
    assign done        = (state == R_SHIFT) && period_end && last_period;

    // first sample ends up in bit 0
    assign aligned = shift_sr >> (tlu_pkg::MAX_CLOCK_CYCLES - n_periods);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= R_IDLE;
            div_cnt   <= '0;
            per_cnt   <= '0;
            tlu_clk_q <= 1'b0;
            ev_ack_q  <= 1'b0;
            wd_req_q  <= 1'b0;
        end
        else
        begin
            case (state)
                R_IDLE:
                begin
                    if (start && ev.payload.read_number)
                    begin
                        state     <= R_SHIFT;
                        div_cnt   <= '0;
                        per_cnt   <= '0;
                        tlu_clk_q <= 1'b1;
                    end
                    else if (start)
                    begin
                        // timestamp word is ready at once
                        state    <= R_OFFER;
                        ev_ack_q <= 1'b1;
                        wd_req_q <= 1'b1;
                    end
                end
                R_SHIFT:
                begin
                    if (done)
                    begin
                        state     <= R_OFFER;
                        div_cnt   <= '0;
                        tlu_clk_q <= 1'b0;
                        ev_ack_q  <= 1'b1;
                        wd_req_q  <= 1'b1;
                    end
                    else if (period_end)
                    begin
                        div_cnt   <= '0;
                        per_cnt   <= per_cnt + 1'b1;
                        tlu_clk_q <= 1'b1;
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                        if (sample)
                            tlu_clk_q <= 1'b0;
                    end
                end
                R_OFFER:
                begin
                    if (wd.ack)
                    begin
                        state    <= R_DRAIN;
                        wd_req_q <= 1'b0;
                    end
                end
                default:
                begin
                    if (!wd.ack)
                        state <= R_IDLE;
                end
            endcase
            // event side closes on its own
            if (ev_ack_q && !ev.req)
                ev_ack_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            shift_sr <= '0;
            cycles_q <= clock_cycles;
            word_q   <= {1'b1, ev.payload.timestamp};
        end
        if (sample)
            shift_sr <= {tlu_data, shift_sr[tlu_pkg::MAX_CLOCK_CYCLES-1:1]};
        if (done)
            word_q <= {1'b1, aligned[tlu_pkg::TIMESTAMP_WIDTH-1:0]};
    end

    assign tlu_clk    = tlu_clk_q;
    assign ev.ack     = ev_ack_q;
    assign wd.req     = wd_req_q;
    assign wd.payload = word_q;

endmodule

// File: hdl/tlu_trigger_handshake.sv
// first pipeline stage: TLU trigger accept, busy, trigger low wait with timeout, timestamp
`timescale 1ns/1ns

module tlu_trigger_handshake
(
    input  logic                             CLK,
    input  logic                             RESET,
    input  logic                             tlu_trigger,
    input  logic                             data_mode,
    input  logic [tlu_pkg::TIMEOUT_WIDTH-1:0] timeout,
    output logic                             tlu_busy,
    output logic                             timeout_error,
    stage_if.source                          ev
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_WAIT_LOW,
        H_OFFER,
        H_RELEASE
    } state_t;

    state_t                              state;
    logic [tlu_pkg::TIMESTAMP_WIDTH-1:0] ts_cnt;
    logic [tlu_pkg::TIMEOUT_WIDTH-1:0]   wait_cnt;
    logic                                req_q;
    logic                                busy_q;
    logic                                timeout_q;
    tlu_pkg::trigger_event_t             event_q;
    logic                                accept;
    logic                                timed_out;

    assign accept    = (state == H_IDLE) && tlu_trigger;
    // a zero timeout waits forever for the trigger to fall
    assign timed_out = (timeout != '0) && (wait_cnt == timeout);

    // free-running timestamp
    always_ff @(posedge CLK)
    begin
        if (RESET)
            ts_cnt <= '0;
        else
            ts_cnt <= ts_cnt + 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= H_IDLE;
            wait_cnt  <= '0;
            req_q     <= 1'b0;
            busy_q    <= 1'b0;
            timeout_q <= 1'b0;
        end
        else
        begin
            case (state)
                H_IDLE:
                begin
                    if (accept)
                    begin
                        state     <= H_WAIT_LOW;
                        wait_cnt  <= '0;
                        busy_q    <= 1'b1;
                        timeout_q <= 1'b0;
                    end
                end
                H_WAIT_LOW:
                begin
                    if (!tlu_trigger)
                    begin
                        state <= H_OFFER;
                        req_q <= 1'b1;
                    end
                    else if (timed_out)
                    begin
                        state     <= H_OFFER;
                        req_q     <= 1'b1;
                        timeout_q <= 1'b1;
                    end
                    else
                        wait_cnt <= wait_cnt + 1'b1;
                end
                H_OFFER:
                begin
                    // reader has the word complete
                    if (ev.ack)
                    begin
                        state <= H_RELEASE;
                        req_q <= 1'b0;
                    end
                end
                default:
                begin
                    // busy drops once the reader closes the handshake
                    if (!ev.ack)
                    begin
                        state  <= H_IDLE;
                        busy_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // event payload, captured at accept
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            event_q.timestamp   <= ts_cnt;
            event_q.read_number <= data_mode;
        end
    end

    assign ev.req        = req_q;
    assign ev.payload    = event_q;
    assign tlu_busy      = busy_q;
    assign timeout_error = timeout_q;

endmodule

// File: hdl/trigger_word_out.sv
// last pipeline stage: one-word buffer offered to the downstream writer over req/ack
`timescale 1ns/1ns

module trigger_word_out
(
    input  logic                   CLK,
    input  logic                   RESET,
    stage_if.sink                  wd,
    output logic                   word_req,
    output tlu_pkg::trigger_word_t word_data,
    input  logic                   word_ack
);

    typedef enum logic [1:0] {
        O_EMPTY,
        O_OFFER,
        O_RELEASE
    } state_t;

    state_t                 state;
    tlu_pkg::trigger_word_t word_q;
    logic                   full;
    logic                   wd_ack_q;
    logic                   word_req_q;
    logic                   capture;

    // buffer stays occupied until word_ack falls
    assign full    = (state != O_EMPTY);
    assign capture = !full && wd.req && !wd_ack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= O_EMPTY;
            wd_ack_q   <= 1'b0;
            word_req_q <= 1'b0;
        end
        else
        begin
            case (state)
                O_EMPTY:
                begin
                    if (capture)
                    begin
                        state      <= O_OFFER;
                        wd_ack_q   <= 1'b1;
                        word_req_q <= 1'b1;
                    end
                end
                O_OFFER:
                begin
                    if (word_ack)
                    begin
                        state      <= O_RELEASE;
                        word_req_q <= 1'b0;
                    end
                end
                default:
                begin
                    if (!word_ack)
                        state <= O_EMPTY;
                end
            endcase
            if (wd_ack_q && !wd.req)
                wd_ack_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (capture)
            word_q <= wd.payload;
    end

    assign wd.ack    = wd_ack_q;
    assign word_req  = word_req_q;
    assign word_data = word_q;

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the TLU controller testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tlu_controller -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: test/tb_tlu_controller.sv
// simulation top that runs the stimulus table through the TLU controller and a writer model
`timescale 1ns/1ns

module tb_tlu_controller;

    localparam int MAX_ROWS    = 16;
    localparam int DRIVE_DELAY = 5;

    logic                                  CLK;
    logic                                  RESET;
    logic                                  tlu_trigger;
    logic                                  tlu_data;
    logic                                  data_mode;
    logic [tlu_pkg::TIMEOUT_WIDTH-1:0]     timeout;
    logic [tlu_pkg::CYCLES_WIDTH-1:0]      clock_cycles;
    logic                                  word_ack;
    logic                                  tlu_busy;
    logic                                  tlu_clk;
    logic                                  timeout_error;
    logic                                  word_req;
    tlu_pkg::trigger_word_t                word_data;

    // stimulus table with one trigger per row
    string                                 row_name    [MAX_ROWS];
    logic                                  row_mode    [MAX_ROWS];
    logic [tlu_pkg::CYCLES_WIDTH-1:0]      row_cycles  [MAX_ROWS];
    logic [tlu_pkg::TIMEOUT_WIDTH-1:0]     row_timeout [MAX_ROWS];
    int                                    row_hold    [MAX_ROWS];
    int                                    row_gap     [MAX_ROWS];
    logic                                  row_drain   [MAX_ROWS];
    logic                                  row_exp_err [MAX_ROWS];
    int                                    n_rows;

    // expected words in trigger order
    logic [31:0]                           exp_words [$];
    string                                 exp_names [$];
    // numbers and bit counts still to be clocked out by the TLU model
    logic [31:0]                           tlu_numbers [$];
    int                                    tlu_lengths [$];

    logic [31:0]                           number_lcg;
    logic [31:0]                           delay_lcg;
    int                                    edge_count;
    int                                    cycle_count;
    int                                    cycle_limit;
    int                                    accepted;
    int                                    received;

    tlu_controller u_tlu_controller
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .tlu_trigger   (tlu_trigger),
        .tlu_data      (tlu_data),
        .tlu_busy      (tlu_busy),
        .tlu_clk       (tlu_clk),
        .data_mode     (data_mode),
        .timeout       (timeout),
        .clock_cycles  (clock_cycles),
        .timeout_error (timeout_error),
        .word_req      (word_req),
        .word_data     (word_data),
        .word_ack      (word_ack)
    );

    initial
    begin
        CLK = 1'b0;
        forever
            #50 CLK = ~CLK;
    end

    // rising edges since reset was released
    always @(posedge CLK)
    begin
        if (RESET)
            edge_count = 0;
        else
            edge_count = edge_count + 1;
    end

    always @(posedge CLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
            fail_and_stop("run did not finish within the cycle limit");
    end

    task automatic fail_and_stop(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("MISMATCH test=%s expected=%h actual=%h", test, expected, actual);
            fail_and_stop("value check failed");
        end
    endtask

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;
        return state;
    endfunction

    // clock_cycles of 0 means the full 32 TLU clocks
    function automatic int readout_bits(input logic [tlu_pkg::CYCLES_WIDTH-1:0] cycles);
        return (cycles == '0) ? tlu_pkg::MAX_CLOCK_CYCLES : int'(cycles);
    endfunction

    function automatic logic [31:0] number_word(input logic [31:0] number, input int n_bits);
        logic [31:0] mask;
        logic [31:0] masked;
        mask   = (n_bits >= 32) ? 32'hffff_ffff : ((32'd1 << n_bits) - 32'd1);
        masked = number & mask;
        return {1'b1, masked[30:0]};
    endfunction

    function automatic int table_cycle_budget();
        int budget;
        int i;
        budget = 200;
        for (i = 0; i < n_rows; i++)
            budget += row_hold[i] + row_gap[i] +
                      3 * (tlu_pkg::TLU_CLOCK_DIVISOR * tlu_pkg::MAX_CLOCK_CYCLES + 50);
        return budget;
    endfunction

    task automatic add_row(input string name, input logic mode,
                           input logic [tlu_pkg::CYCLES_WIDTH-1:0] cycles,
                           input logic [tlu_pkg::TIMEOUT_WIDTH-1:0] tmo,
                           input int hold, input int gap, input logic drain, input logic exp_err);
        row_name[n_rows]    = name;
        row_mode[n_rows]    = mode;
        row_cycles[n_rows]  = cycles;
        row_timeout[n_rows] = tmo;
        row_hold[n_rows]    = hold;
        row_gap[n_rows]     = gap;
        row_drain[n_rows]   = drain;
        row_exp_err[n_rows] = exp_err;
        n_rows++;
    endtask

    task automatic load_table();
        n_rows = 0;
        //       name             mode  cycles tmo    hold gap drain err
        add_row("data_cc16",     1'b1, 5'd16, 8'd0,  3,   20,  1'b0, 1'b0);
        add_row("data_cc0",      1'b1, 5'd0,  8'd0,  3,   20,  1'b1, 1'b0);
        add_row("data_cc5",      1'b1, 5'd5,  8'd0,  3,   20,  1'b1, 1'b0);
        add_row("ts_first",      1'b0, 5'd5,  8'd0,  2,   9,   1'b1, 1'b0);
        add_row("ts_second",     1'b0, 5'd5,  8'd0,  2,   20,  1'b0, 1'b0);
        add_row("timeout_hit",   1'b1, 5'd16, 8'd10, 30,  20,  1'b1, 1'b1);
        add_row("after_timeout", 1'b1, 5'd16, 8'd10, 3,   20,  1'b0, 1'b0);
        add_row("burst_ts_0",    1'b0, 5'd16, 8'd0,  1,   1,   1'b1, 1'b0);
        add_row("burst_ts_1",    1'b0, 5'd16, 8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_ts_2",    1'b0, 5'd16, 8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_ts_3",    1'b0, 5'd16, 8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_ts_4",    1'b0, 5'd16, 8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_data_0",  1'b1, 5'd2,  8'd0,  1,   1,   1'b1, 1'b0);
        add_row("burst_data_1",  1'b1, 5'd2,  8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_data_2",  1'b1, 5'd2,  8'd0,  1,   1,   1'b0, 1'b0);
        add_row("burst_data_3",  1'b1, 5'd2,  8'd0,  1,   1,   1'b0, 1'b0);
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    // every accepted trigger has left the writer
    task automatic wait_for_drain();
        while (received != accepted || word_ack)
            next_cycle();
    endtask

    // TLU model drives the next bit of the current number on each rising tlu_clk
    initial
    begin : tlu_model
        logic [31:0] number;
        int          length;
        int          bit_index;
        number    = '0;
        length    = 1;
        bit_index = 0;
        forever
        begin
            @(posedge tlu_clk);
            #DRIVE_DELAY;
            if (bit_index == 0 && tlu_numbers.size() == 0)
                fail_and_stop("TLU clock started with no trigger number pending");
            else
            begin
                if (bit_index == 0)
                begin
                    number = tlu_numbers.pop_front();
                    length = tlu_lengths.pop_front();
                end
                tlu_data  = number[bit_index];
                bit_index = (bit_index + 1 == length) ? 0 : bit_index + 1;
            end
        end
    end

    // downstream writer with random ack delay
    initial
    begin : writer_model
        int delay;
        @(negedge RESET);
        forever
        begin
            next_cycle();
            if (word_req)
            begin
                delay = int'((next_random(delay_lcg) >> 16) % 32'd41);
                repeat (delay)
                    next_cycle();
                if (exp_words.size() == 0)
                    fail_and_stop("word offered with no trigger outstanding");
                else
                    check_value(exp_names.pop_front(), exp_words.pop_front(), word_data);
                word_ack = 1'b1;
                received++;
                while (word_req)
                    next_cycle();
                word_ack = 1'b0;
            end
        end
    end

    initial
    begin : main
        int          row;
        logic [31:0] number;
        logic [31:0] expected;
        logic        prev_busy;
        RESET        = 1'b1;
        tlu_trigger  = 1'b0;
        tlu_data     = 1'b0;
        data_mode    = 1'b0;
        timeout      = '0;
        clock_cycles = '0;
        word_ack     = 1'b0;
        number_lcg   = 32'h2421;
        delay_lcg    = 32'h2421;
        edge_count   = 0;
        cycle_count  = 0;
        accepted     = 0;
        received     = 0;
        load_table();
        cycle_limit = table_cycle_budget();

        repeat (10)
            @(posedge CLK);
        #DRIVE_DELAY;
        RESET = 1'b0;
        check_value("after_reset", 32'd0, {28'd0, tlu_busy, tlu_clk, timeout_error, word_req});

        for (row = 0; row < n_rows; row++)
        begin
            if (row_drain[row])
                wait_for_drain();
            data_mode    = row_mode[row];
            clock_cycles = row_cycles[row];
            timeout      = row_timeout[row];
            number       = next_random(number_lcg);
            // three triggers in flight fill every stage
            if (accepted - received >= 3)
                check_value({row_name[row], "_busy"}, 32'd1, 32'(tlu_busy));
            prev_busy   = tlu_busy;
            tlu_trigger = 1'b1;
            next_cycle();
            // busy low means the handshake is idle and takes the trigger at the next edge
            while (prev_busy)
            begin
                prev_busy = tlu_busy;
                next_cycle();
            end
            check_value({row_name[row], "_accept"}, 32'd1, 32'(tlu_busy));
            accepted++;
            if (row_mode[row])
            begin
                tlu_numbers.push_back(number);
                tlu_lengths.push_back(readout_bits(row_cycles[row]));
                expected = number_word(number, readout_bits(row_cycles[row]));
            end
            else
                expected = {1'b1, 31'(edge_count - 1)};
            exp_words.push_back(expected);
            exp_names.push_back(row_name[row]);

            repeat (row_hold[row])
                next_cycle();
            check_value({row_name[row], "_timeout_error"}, 32'(row_exp_err[row]),
                        32'(timeout_error));
            tlu_trigger = 1'b0;
            repeat (row_gap[row])
                next_cycle();
        end

        wait_for_drain();
        repeat (5)
            next_cycle();
        check_value("idle_at_end", 32'd0, {30'd0, tlu_busy, word_req});

        $display("TEST PASS");
        $finish;
    end

endmodule
